// ==== include/csr_params.svh ====
//////////////////////////////
// csr address map, fixed id values
// and performance counter sizing
//////////////////////////////

`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

//////////////////////////////
// machine mode addresses
//////////////////////////////
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCPUID     12'hF00   // read only
`define CSR_ADDR_MIMPID     12'hF01   // read only
`define CSR_ADDR_MHARTID    12'hF10   // read only, cluster and core id

//////////////////////////////
// performance counter addresses
//////////////////////////////
`define CSR_ADDR_PCER       12'h7A0   // event enable mask
`define CSR_ADDR_PCMR       12'h7A1   // mode, bit 0 enable, bit 1 saturate
`define CSR_ADDR_PCCR_ALL   12'h79F   // all counters at once, reads zero
`define CSR_ADDR_PCCR_BASE  12'h780   // counter 0, one address per counter

// fixed read values
`define CSR_MCPUID_VAL      32'h0000_0100   // rv32i
`define CSR_MIMPID_VAL      32'h0000_8000

// built-in event count, external inputs follow these
`define CSR_NUM_CORE_EVENTS 10

// counting on, saturation on
`define CSR_PCMR_RESET      2'b11

// counter index field, addr[4:0] inside the 0x780 window
`define CSR_PCCR_IDX_W      5

`endif

// ==== hw/csr_pkg.sv ====
//////////////////////////////
// csr op encoding, address and data
// types, core event bit positions
//////////////////////////////

package csr_pkg;

  // access op, driven every cycle on the csr port
  typedef enum logic [1:0] {
    NONE  = 2'b00,   // read only, no write strobe
    WRITE = 2'b01,
    SET   = 2'b10,   // old | wdata
    CLEAR = 2'b11    // old & ~wdata
  } csr_op_e;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // bit positions in the event vector and in pcer
  typedef enum logic [3:0] {
    CYCLES     = 4'd0,
    INSTR      = 4'd1,
    LD_STALL   = 4'd2,   // load use hazard
    JR_STALL   = 4'd3,   // jump register hazard
    IMISS      = 4'd4,
    LOAD       = 4'd5,
    STORE      = 4'd6,
    JUMP       = 4'd7,
    BRANCH     = 4'd8,
    COMPRESSED = 4'd9
  } perf_event_e;

endpackage

// ==== hw/csr_access.sv ====
//////////////////////////////
// csr access stage: read steering,
// read-modify-write value, write strobe
//////////////////////////////

`timescale 1ns/1ps

module csr_access
(
  input  logic                clk,
  input  logic                rst_n,

  // csr port
  input  csr_pkg::csr_op_e    csr_op_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,

  // register groups
  input  logic                mach_hit_i,
  input  csr_pkg::csr_data_t  mach_rdata_i,
  input  logic                perf_hit_i,
  input  csr_pkg::csr_data_t  perf_rdata_i,

  output csr_pkg::csr_data_t  csr_rdata_o,
  output logic                csr_we_o,
  output csr_pkg::csr_data_t  csr_wnew_o
);

  csr_pkg::csr_data_t rdata_sel;   // value the op works on

  //////////////////////////////
  // read steering
  //////////////////////////////

  // groups decode, this stage only looks at hit flags
  always_comb
  begin
    rdata_sel = '0;                      // unclaimed address reads zero
    if (mach_hit_i)
      rdata_sel = mach_rdata_i;
    else if (perf_hit_i)
      rdata_sel = perf_rdata_i;
  end

  assign csr_rdata_o = rdata_sel;

  //////////////////////////////
  // op logic
  //////////////////////////////

  always_comb
  begin
    unique case (csr_op_i)
      csr_pkg::WRITE: csr_wnew_o = csr_wdata_i;
      csr_pkg::SET:   csr_wnew_o = rdata_sel | csr_wdata_i;
      csr_pkg::CLEAR: csr_wnew_o = rdata_sel & ~csr_wdata_i;
      default:        csr_wnew_o = rdata_sel;   // none, value unchanged
    endcase
  end

  assign csr_we_o = (csr_op_i != csr_pkg::NONE);

  // op must always be driven once out of reset
  a_op_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(csr_op_i))
    else $error("csr op unknown");

  // address map of the two groups must not overlap
  a_one_hit : assert property (@(posedge clk) disable iff (!rst_n)
    !(mach_hit_i && perf_hit_i))
    else $error("both csr groups claim the address");

endmodule

// ==== hw/machine_csrs.sv ====
//////////////////////////////
// machine mode csrs with mstatus ie,
// mscratch, mepc and read-only id regs
//////////////////////////////

`timescale 1ns/1ps

`include "csr_params.svh"

module machine_csrs
(
  input  logic                clk,
  input  logic                rst_n,

  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  logic                csr_we_i,
  input  csr_pkg::csr_data_t  csr_wnew_i,     // post-op write value

  input  logic [4:0]          core_id_i,
  input  logic [4:0]          cluster_id_i,

  // exception pc saves
  input  csr_pkg::csr_data_t  curr_pc_if_i,
  input  csr_pkg::csr_data_t  curr_pc_id_i,
  input  logic                save_pc_if_i,
  input  logic                save_pc_id_i,

  output logic                hit_o,
  output csr_pkg::csr_data_t  rdata_o,
  output logic                irq_enable_o,
  output csr_pkg::csr_data_t  epcr_o
);

  logic               irq_enable_q;
  csr_pkg::csr_data_t mscratch_q;
  csr_pkg::csr_data_t mepc_q;
  logic               ro_sel;          // one of the id registers

  //////////////////////////////
  // decode and read
  //////////////////////////////

  always_comb
  begin
    hit_o   = 1'b1;
    rdata_o = '0;
    unique case (csr_addr_i)
      `CSR_ADDR_MSTATUS:  rdata_o = {29'b0, 2'b11, irq_enable_q};   // always m-mode
      `CSR_ADDR_MSCRATCH: rdata_o = mscratch_q;
      `CSR_ADDR_MEPC:     rdata_o = mepc_q;
      `CSR_ADDR_MCPUID:   rdata_o = `CSR_MCPUID_VAL;
      `CSR_ADDR_MIMPID:   rdata_o = `CSR_MIMPID_VAL;
      `CSR_ADDR_MHARTID:  rdata_o = {22'b0, cluster_id_i, core_id_i};
      default:            hit_o   = 1'b0;
    endcase
  end

  assign ro_sel = (csr_addr_i == `CSR_ADDR_MCPUID) ||
                  (csr_addr_i == `CSR_ADDR_MIMPID) ||
                  (csr_addr_i == `CSR_ADDR_MHARTID);

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_enable_q <= 1'b0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
    end
    else
    begin
      if (csr_we_i && (csr_addr_i == `CSR_ADDR_MSTATUS))
        irq_enable_q <= csr_wnew_i[0];       // only ie is writable
      if (csr_we_i && (csr_addr_i == `CSR_ADDR_MSCRATCH))
        mscratch_q <= csr_wnew_i;
      // exception saves beat sw and if beats id
      if (save_pc_if_i)
        mepc_q <= curr_pc_if_i;
      else if (save_pc_id_i)
        mepc_q <= curr_pc_id_i;
      else if (csr_we_i && (csr_addr_i == `CSR_ADDR_MEPC))
        mepc_q <= csr_wnew_i;
    end
  end

  assign irq_enable_o = irq_enable_q;
  assign epcr_o       = mepc_q;

  // write aimed at an id register is dropped by every writable reg
  a_ro_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (csr_we_i && ro_sel && !save_pc_if_i && !save_pc_id_i) |=>
    ($stable(irq_enable_q) && $stable(mscratch_q) && $stable(mepc_q)))
    else $error("write to read-only csr changed a register");

endmodule

// ==== hw/perf_counters.sv ====
//////////////////////////////
// performance counters: event qualify,
// pcer and pcmr, counter array
//////////////////////////////

`timescale 1ns/1ps

`include "csr_params.svh"

module perf_counters
#(
  parameter int N_EXT_PERF_COUNTERS = 2
)
(
  input  logic                           clk,
  input  logic                           rst_n,

  input  csr_pkg::csr_addr_t             csr_addr_i,
  input  logic                           csr_we_i,
  input  csr_pkg::csr_data_t             csr_wnew_i,

  // core events, levels
  input  logic                           id_valid_i,        // id stage done
  input  logic                           is_decoding_i,
  input  logic                           is_compressed_i,
  input  logic                           imiss_i,
  input  logic                           jump_i,
  input  logic                           branch_i,
  input  logic                           ld_stall_i,
  input  logic                           jr_stall_i,
  input  logic                           mem_load_i,
  input  logic                           mem_store_i,
  input  logic [N_EXT_PERF_COUNTERS-1:0] ext_counters_i,

  output logic                           hit_o,
  output csr_pkg::csr_data_t             rdata_o
);

  localparam int N_PERF_COUNTERS = `CSR_NUM_CORE_EVENTS + N_EXT_PERF_COUNTERS;
  localparam int IDX_W           = `CSR_PCCR_IDX_W;

  logic                                   id_valid_q;
  logic [N_PERF_COUNTERS-1:0]             evt_in;        // qualified events
  logic [N_PERF_COUNTERS-1:0]             inc_q;         // registered increment request
  logic [N_PERF_COUNTERS-1:0]             pcer_q;
  logic [1:0]                             pcmr_q;
  csr_pkg::csr_data_t [N_PERF_COUNTERS-1:0] cnt_q;
  csr_pkg::csr_data_t [N_PERF_COUNTERS-1:0] cnt_n;
  logic [N_PERF_COUNTERS-1:0]             cnt_wr;        // sw write per counter

  logic [IDX_W-1:0] pccr_idx;
  logic             pcer_sel;
  logic             pcmr_sel;
  logic             all_sel;
  logic             idx_sel;

  //////////////////////////////
  // event qualification
  //////////////////////////////

  assign evt_in[csr_pkg::CYCLES]     = 1'b1;
  assign evt_in[csr_pkg::INSTR]      = id_valid_i & is_decoding_i;
  assign evt_in[csr_pkg::LD_STALL]   = ld_stall_i & id_valid_q;
  assign evt_in[csr_pkg::JR_STALL]   = jr_stall_i & id_valid_q;
  assign evt_in[csr_pkg::IMISS]      = imiss_i;
  assign evt_in[csr_pkg::LOAD]       = mem_load_i;
  assign evt_in[csr_pkg::STORE]      = mem_store_i;
  assign evt_in[csr_pkg::JUMP]       = jump_i & id_valid_q;
  assign evt_in[csr_pkg::BRANCH]     = branch_i & id_valid_q;
  assign evt_in[csr_pkg::COMPRESSED] = id_valid_i & is_decoding_i & is_compressed_i;

  // external events sit above the core ones
  for (genvar e = 0; e < N_EXT_PERF_COUNTERS; e++)
  begin : g_ext_evt
    assign evt_in[`CSR_NUM_CORE_EVENTS + e] = ext_counters_i[e];
  end

  //////////////////////////////
  // decode and read
  //////////////////////////////

  assign pccr_idx = csr_addr_i[IDX_W-1:0];
  assign pcer_sel = (csr_addr_i == `CSR_ADDR_PCER);
  assign pcmr_sel = (csr_addr_i == `CSR_ADDR_PCMR);
  assign all_sel  = (csr_addr_i == `CSR_ADDR_PCCR_ALL);
  assign idx_sel  = (csr_addr_i[11:IDX_W] == `CSR_ADDR_PCCR_BASE >> IDX_W) && !all_sel &&
                    (32'(pccr_idx) < N_PERF_COUNTERS);   // past last counter: no hit

  assign hit_o = pcer_sel | pcmr_sel | all_sel | idx_sel;

  always_comb
  begin
    rdata_o = '0;                                   // all-counter reads zero
    if (pcer_sel)
      rdata_o[N_PERF_COUNTERS-1:0] = pcer_q;
    else if (pcmr_sel)
      rdata_o[1:0] = pcmr_q;
    else if (idx_sel)
      rdata_o = cnt_q[pccr_idx];
  end

  //////////////////////////////
  // counter update
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < N_PERF_COUNTERS; i++)
    begin
      cnt_wr[i] = csr_we_i && (all_sel || (idx_sel && (pccr_idx == IDX_W'(i))));
      cnt_n[i]  = cnt_q[i];
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + 32'd1;               // wraps when not saturating
      if (cnt_wr[i])
        cnt_n[i] = csr_wnew_i;                     // sw write beats increment
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= `CSR_PCMR_RESET;
      cnt_q      <= '0;
    end
    else
    begin
      id_valid_q <= id_valid_i;
      inc_q      <= evt_in & pcer_q & {N_PERF_COUNTERS{pcmr_q[0]}};
      if (csr_we_i && pcer_sel)
        pcer_q <= csr_wnew_i[N_PERF_COUNTERS-1:0];
      if (csr_we_i && pcmr_sel)
        pcmr_q <= csr_wnew_i[1:0];
      cnt_q <= cnt_n;
    end
  end

  // saturated counter stays put unless software writes it
  for (genvar g = 0; g < N_PERF_COUNTERS; g++)
  begin : g_sat_chk
    a_sat_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (pcmr_q[1] && (cnt_q[g] == '1) && !cnt_wr[g]) |=> (cnt_q[g] != '0))
      else $error("saturated counter %0d wrapped", g);
  end

endmodule

// ==== hw/cs_registers.sv ====
//////////////////////////////
// csr subsystem top, wires the access
// stage to both register groups
//////////////////////////////

`timescale 1ns/1ps

module cs_registers
#(
  parameter int N_EXT_PERF_COUNTERS = 2
)
(
  input  logic                           clk,
  input  logic                           rst_n,

  // ids
  input  logic [4:0]                     core_id_i,
  input  logic [4:0]                     cluster_id_i,

  // csr port, read comb, write on next edge
  input  csr_pkg::csr_addr_t             csr_addr_i,
  input  csr_pkg::csr_op_e               csr_op_i,
  input  csr_pkg::csr_data_t             csr_wdata_i,
  output csr_pkg::csr_data_t             csr_rdata_o,

  // exception pc saves
  input  csr_pkg::csr_data_t             curr_pc_if_i,
  input  csr_pkg::csr_data_t             curr_pc_id_i,
  input  logic                           save_pc_if_i,
  input  logic                           save_pc_id_i,
  output logic                           irq_enable_o,
  output csr_pkg::csr_data_t             epcr_o,

  // events
  input  logic                           id_valid_i,
  input  logic                           is_decoding_i,
  input  logic                           is_compressed_i,
  input  logic                           imiss_i,
  input  logic                           jump_i,
  input  logic                           branch_i,
  input  logic                           ld_stall_i,
  input  logic                           jr_stall_i,
  input  logic                           mem_load_i,
  input  logic                           mem_store_i,
  input  logic [N_EXT_PERF_COUNTERS-1:0] ext_counters_i
);

  logic               csr_we;
  csr_pkg::csr_data_t csr_wnew;     // post-op value to both groups
  logic               mach_hit;
  logic               perf_hit;
  csr_pkg::csr_data_t mach_rdata;
  csr_pkg::csr_data_t perf_rdata;

  //////////////////////////////
  // access stage
  //////////////////////////////

  csr_access u_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .mach_hit_i   (mach_hit),
    .mach_rdata_i (mach_rdata),
    .perf_hit_i   (perf_hit),
    .perf_rdata_i (perf_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .csr_we_o     (csr_we),
    .csr_wnew_o   (csr_wnew)
  );

  //////////////////////////////
  // register groups
  //////////////////////////////

  machine_csrs u_mach (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_addr_i   (csr_addr_i),
    .csr_we_i     (csr_we),
    .csr_wnew_i   (csr_wnew),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .curr_pc_if_i (curr_pc_if_i),
    .curr_pc_id_i (curr_pc_id_i),
    .save_pc_if_i (save_pc_if_i),
    .save_pc_id_i (save_pc_id_i),
    .hit_o        (mach_hit),
    .rdata_o      (mach_rdata),
    .irq_enable_o (irq_enable_o),
    .epcr_o       (epcr_o)
  );

  perf_counters #(
    .N_EXT_PERF_COUNTERS (N_EXT_PERF_COUNTERS)
  ) u_perf (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_addr_i      (csr_addr_i),
    .csr_we_i        (csr_we),
    .csr_wnew_i      (csr_wnew),
    .id_valid_i      (id_valid_i),
    .is_decoding_i   (is_decoding_i),
    .is_compressed_i (is_compressed_i),
    .imiss_i         (imiss_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .ld_stall_i      (ld_stall_i),
    .jr_stall_i      (jr_stall_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .ext_counters_i  (ext_counters_i),
    .hit_o           (perf_hit),
    .rdata_o         (perf_rdata)
  );

endmodule

// ==== tests/cs_registers_tb.sv ====
//////////////////////////////
// csr subsystem testbench with stimulus
// table, reference model and checks
//////////////////////////////

`timescale 1ns/1ps

`include "csr_params.svh"

module cs_registers_tb;

  localparam int NCNT = `CSR_NUM_CORE_EVENTS + 2;   // core + two external counters
  localparam logic [4:0] CORE_ID    = 5'd3;
  localparam logic [4:0] CLUSTER_ID = 5'd17;

  typedef struct {
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_data_t wdata;
    logic [2:0]         evt;         // {ext[1:0], mem_load}
    logic               sv_if;
    logic               sv_id;
    csr_pkg::csr_data_t pc_if;
    csr_pkg::csr_data_t pc_id;
    csr_pkg::csr_data_t exp_rdata;   // read after the edge at the same address
    logic               exp_irq;
    csr_pkg::csr_data_t exp_epcr;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  csr_pkg::csr_addr_t csr_addr;
  csr_pkg::csr_op_e   csr_op;
  csr_pkg::csr_data_t csr_wdata, csr_rdata, curr_pc_if, curr_pc_id, epcr;
  logic save_pc_if, save_pc_id, irq_enable, mem_load;
  logic [1:0] ext_counters;

  row_t rows[$];
  int   n_rows  = 0;
  bit   tbl_done = 1'b0;

  // reference model state
  logic               m_ie;
  csr_pkg::csr_data_t m_scratch, m_epc;
  logic [NCNT-1:0]    m_pcer, m_inc;      // m_inc is the pending increment
  logic [1:0]         m_pcmr;
  csr_pkg::csr_data_t m_cnt [NCNT];

  cs_registers #(.N_EXT_PERF_COUNTERS(2)) dut (
    .clk(clk), .rst_n(rst_n), .core_id_i(CORE_ID), .cluster_id_i(CLUSTER_ID),
    .csr_addr_i(csr_addr), .csr_op_i(csr_op), .csr_wdata_i(csr_wdata),
    .csr_rdata_o(csr_rdata), .curr_pc_if_i(curr_pc_if), .curr_pc_id_i(curr_pc_id),
    .save_pc_if_i(save_pc_if), .save_pc_id_i(save_pc_id), .irq_enable_o(irq_enable),
    .epcr_o(epcr), .id_valid_i(1'b0), .is_decoding_i(1'b0), .is_compressed_i(1'b0),
    .imiss_i(1'b0), .jump_i(1'b0), .branch_i(1'b0), .ld_stall_i(1'b0),
    .jr_stall_i(1'b0), .mem_load_i(mem_load), .mem_store_i(1'b0),
    .ext_counters_i(ext_counters)
  );

  initial
  begin
    forever #2 clk = ~clk;   // 4 ns period
  end

  task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic csr_pkg::csr_data_t ref_read(csr_pkg::csr_addr_t a);
    case (a)
      `CSR_ADDR_MSTATUS:  return 32'h0000_0006 | 32'(m_ie);   // mode bits fixed
      `CSR_ADDR_MSCRATCH: return m_scratch;
      `CSR_ADDR_MEPC:     return m_epc;
      `CSR_ADDR_MCPUID:   return 32'h0000_0100;
      `CSR_ADDR_MIMPID:   return 32'h0000_8000;
      `CSR_ADDR_MHARTID:  return (32'(CLUSTER_ID) << 5) | 32'(CORE_ID);
      `CSR_ADDR_PCER:     return 32'(m_pcer);
      `CSR_ADDR_PCMR:     return 32'(m_pcmr);
      default:
        if (a >= `CSR_ADDR_PCCR_BASE && a < `CSR_ADDR_PCCR_BASE + NCNT)
          return m_cnt[a - `CSR_ADDR_PCCR_BASE];
    endcase
    return '0;                                          // unclaimed or all-counter
  endfunction

  // one table row per clock edge of the model
  task automatic add_cycle(csr_pkg::csr_op_e op, csr_pkg::csr_addr_t addr,
                           csr_pkg::csr_data_t wdata, logic [2:0] evt,
                           logic sv_if, logic sv_id);
    row_t               r;
    csr_pkg::csr_data_t wnew;
    logic               we;
    logic [NCNT-1:0]    ev;
    r = '{op, addr, wdata, evt, sv_if, sv_id, $urandom, $urandom, '0, 1'b0, '0};
    case (op)
      csr_pkg::WRITE: wnew = wdata;
      csr_pkg::SET:   wnew = ref_read(addr) | wdata;
      csr_pkg::CLEAR: wnew = ref_read(addr) & ~wdata;
      default:        wnew = ref_read(addr);
    endcase
    we = (op != csr_pkg::NONE);
    for (int i = 0; i < NCNT; i++)
    begin
      if (m_inc[i] && !(m_pcmr[1] && m_cnt[i] == 32'hFFFF_FFFF))
        m_cnt[i] = m_cnt[i] + 32'd1;                    // wraps unless saturating
      if (we && (addr == `CSR_ADDR_PCCR_ALL || addr == `CSR_ADDR_PCCR_BASE + i))
        m_cnt[i] = wnew;                                // write wins
    end
    ev = '0;
    ev[csr_pkg::CYCLES] = 1'b1;
    ev[csr_pkg::LOAD]   = evt[0];
    ev[`CSR_NUM_CORE_EVENTS +: 2] = evt[2:1];
    m_inc = ev & m_pcer & {NCNT{m_pcmr[0]}};            // old enables
    if (we && addr == `CSR_ADDR_PCER)     m_pcer = wnew[NCNT-1:0];
    if (we && addr == `CSR_ADDR_PCMR)     m_pcmr = wnew[1:0];
    if (we && addr == `CSR_ADDR_MSTATUS)  m_ie = wnew[0];
    if (we && addr == `CSR_ADDR_MSCRATCH) m_scratch = wnew;
    if (sv_if)
      m_epc = r.pc_if;                                  // if beats id beats sw
    else if (sv_id)
      m_epc = r.pc_id;
    else if (we && addr == `CSR_ADDR_MEPC)
      m_epc = wnew;
    r.exp_rdata = ref_read(addr);
    r.exp_irq   = m_ie;
    r.exp_epcr  = m_epc;
    rows.push_back(r);
  endtask

  task automatic add_access(csr_pkg::csr_op_e op, int addr, csr_pkg::csr_data_t wdata);
    add_cycle(op, 12'(addr), wdata, 3'b000, 1'b0, 1'b0);
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic build_table();
    m_ie      = 1'b0;
    m_scratch = '0;
    m_epc     = '0;
    m_pcer    = '0;
    m_inc     = '0;
    m_pcmr    = `CSR_PCMR_RESET;
    m_cnt     = '{default: '0};
    // reset values
    add_access(csr_pkg::NONE, `CSR_ADDR_MSTATUS, '0);
    add_access(csr_pkg::NONE, `CSR_ADDR_MSCRATCH, '0);
    add_access(csr_pkg::NONE, `CSR_ADDR_PCER, '0);
    add_access(csr_pkg::NONE, `CSR_ADDR_PCMR, '0);
    for (int i = 0; i < NCNT; i++)
      add_access(csr_pkg::NONE, `CSR_ADDR_PCCR_BASE + i, '0);
    // four ops on mscratch and mstatus
    add_access(csr_pkg::WRITE, `CSR_ADDR_MSCRATCH, $urandom);
    add_access(csr_pkg::SET,   `CSR_ADDR_MSCRATCH, $urandom);
    add_access(csr_pkg::CLEAR, `CSR_ADDR_MSCRATCH, $urandom);
    add_access(csr_pkg::NONE,  `CSR_ADDR_MSCRATCH, $urandom);
    add_access(csr_pkg::WRITE, `CSR_ADDR_MSTATUS, 32'h1);
    add_access(csr_pkg::CLEAR, `CSR_ADDR_MSTATUS, $urandom);
    add_access(csr_pkg::SET,   `CSR_ADDR_MSTATUS, $urandom | 32'h1);
    add_access(csr_pkg::CLEAR, `CSR_ADDR_MSTATUS, 32'h1);
    // read-only ids and an unclaimed address
    add_access(csr_pkg::WRITE, `CSR_ADDR_MCPUID, $urandom);
    add_access(csr_pkg::SET,   `CSR_ADDR_MIMPID, $urandom);
    add_access(csr_pkg::WRITE, `CSR_ADDR_MHARTID, $urandom);
    add_access(csr_pkg::NONE,  12'h123, '0);
    add_access(csr_pkg::WRITE, 12'h123, $urandom);
    // mepc saves against a software write
    add_cycle(csr_pkg::WRITE, `CSR_ADDR_MEPC, $urandom, 3'b000, 1'b1, 1'b1);
    add_cycle(csr_pkg::WRITE, `CSR_ADDR_MEPC, $urandom, 3'b000, 1'b0, 1'b1);
    add_cycle(csr_pkg::WRITE, `CSR_ADDR_MEPC, $urandom, 3'b000, 1'b0, 1'b0);
    add_cycle(csr_pkg::NONE,  `CSR_ADDR_MEPC, '0, 3'b000, 1'b1, 1'b0);
    // load and ext0 count while ext1 and cycles stay masked
    add_access(csr_pkg::WRITE, `CSR_ADDR_PCER, (1 << csr_pkg::LOAD) | (1 << 10));
    for (int k = 0; k < 8; k++)
      add_cycle(csr_pkg::NONE, 12'h785, '0, 3'((k * 3 + 1) % 8), 1'b0, 1'b0);
    add_access(csr_pkg::NONE, 12'h785, '0);
    add_access(csr_pkg::NONE, 12'h785, '0);
    add_access(csr_pkg::NONE, 12'h78A, '0);
    add_access(csr_pkg::NONE, 12'h78B, '0);
    add_access(csr_pkg::NONE, 12'h780, '0);
    add_access(csr_pkg::CLEAR, `CSR_ADDR_PCMR, 32'h1);  // counting off
    for (int k = 0; k < 4; k++)
      add_cycle(csr_pkg::NONE, 12'h78A, '0, 3'b011, 1'b0, 1'b0);
    add_access(csr_pkg::NONE, 12'h785, '0);
    add_access(csr_pkg::NONE, 12'h78A, '0);
    // saturation, wrap, all-counter access
    add_access(csr_pkg::SET,   `CSR_ADDR_PCMR, 32'h1);
    add_access(csr_pkg::WRITE, `CSR_ADDR_PCER, 32'h1 << csr_pkg::CYCLES);
    add_access(csr_pkg::WRITE, 12'h780, 32'hFFFF_FFFF);
    for (int k = 0; k < 3; k++)
      add_access(csr_pkg::NONE, 12'h780, '0);
    add_access(csr_pkg::WRITE, `CSR_ADDR_PCMR, 32'h1);  // saturation off
    for (int k = 0; k < 3; k++)
      add_access(csr_pkg::NONE, 12'h780, '0);
    add_access(csr_pkg::WRITE, `CSR_ADDR_PCCR_ALL, $urandom);
    add_access(csr_pkg::NONE,  12'h785, '0);
    add_access(csr_pkg::NONE,  12'h78B, '0);
    add_access(csr_pkg::CLEAR, `CSR_ADDR_PCCR_ALL, 32'hFFFF_FFFF);
    add_access(csr_pkg::NONE,  12'h785, '0);
    add_access(csr_pkg::NONE,  12'h780, '0);
    n_rows = rows.size();
  endtask

  //////////////////////////////
  // run
  //////////////////////////////

  initial
  begin
    void'($urandom(42));
    rst_n        = 1'b0;
    csr_addr     = '0;
    csr_op       = csr_pkg::NONE;
    csr_wdata    = '0;
    curr_pc_if   = '0;
    curr_pc_id   = '0;
    save_pc_if   = 1'b0;
    save_pc_id   = 1'b0;
    mem_load     = 1'b0;
    ext_counters = '0;
    build_table();
    tbl_done = 1'b1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    foreach (rows[i])
    begin
      csr_op       = rows[i].op;
      csr_addr     = rows[i].addr;
      csr_wdata    = rows[i].wdata;
      mem_load     = rows[i].evt[0];
      ext_counters = rows[i].evt[2:1];
      save_pc_if   = rows[i].sv_if;
      save_pc_id   = rows[i].sv_id;
      curr_pc_if   = rows[i].pc_if;
      curr_pc_id   = rows[i].pc_id;
      @(negedge clk);                                   // edge in between
      compare("csr_rdata_o", csr_rdata, rows[i].exp_rdata);
      compare("irq_enable_o", 32'(irq_enable), 32'(rows[i].exp_irq));
      compare("epcr_o", epcr, rows[i].exp_epcr);
    end
    $display("Regression passed");
    $finish;
  end

  // watchdog over table length plus margin
  initial
  begin
    wait (tbl_done);
    #(n_rows * 4 + 200);
    $display("watchdog expired before the stimulus table finished");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== tb.f ====
+incdir+include
hw/csr_pkg.sv
hw/csr_access.sv
hw/machine_csrs.sv
hw/perf_counters.sv
hw/cs_registers.sv
tests/cs_registers_tb.sv
